/* sim/cpu_testdata.hex */
// Program length, program words, data word count, data words, store count,
// store pairs as address then data, and the expected final status
0060                                // program length
// ALU operations, each result stored with STORI
07011234 070200F0 07030004          // MOVI r1, r2, r3
0A010200 19010100                   // ADD gives 1324
0B010300 19010102                   // SUB gives 1320
0F010200 19010104                   // OR gives 13F0
10010300 19010106                   // XOR gives 13F4
0E010200 19010108                   // AND gives 00F0
11010300 1901010A                   // SHL gives 0F00
07048000 06050400 1905010C          // MOVI r4 then MOV r5 gives 8000
12050300 1905010E                   // SHRA gives F800
13040300 19040110                   // SHRL gives 0800
// Compare operands and the marker value in r7
070700AA 07080005 07090003
070A7FFF 070BFFFF 070C0001
41007800 190702FE                   // JMPI skips a store
070F0084 400F0000 190702FC          // JMP r15 skips a store
// Flag op, jump, marker store that runs only when the jump falls through
15080200 42009000 19070202          // JEQ taken
14080800 43009C00 19070204          // JNE falls through
14080900 4400A800 19070206          // JG taken
14090800 4500B400 19070208          // JGE falls through
14090800 4800C000 1907020A          // JL taken
14080900 4900CC00 1907020C          // JLE falls through
14080900 4600D800 1907020E          // JA taken
0B0D0800 4700E400 19070210          // SUB borrow, JAE falls through
14090800 4A00F000 19070212          // JB taken
14080900 4B00FC00 19070214          // JBE falls through
140A0B00 4C010800 19070216          // JO taken
140A0B00 4D011400 19070218          // JNO falls through
150B0B00 4E012000 1907021A          // TST negative, JS taken
0A0C0B00 4F012C00 1907021C          // ADD carry, JNS taken
14080800 00000000 42013C00 1907021E // NOP clears zero so JEQ falls through
// Memory access
05010000 19010300                   // LOADI BEEF
07020002 07040302 04030200 18030400 // LOAD r3 then STOR r3 to 0302
05050302 19050304                   // read back the stored word
// Multiply with products wider than a word
05060004 05070006 0C060700 19060306 // 8001 times 3
07081234 07090100 0C080900 19080308 // 1234 times 0100
FF000000                            // undefined opcode halts
0004                                // data word count
BEEF 1357 8001 0003
0015                                // store count
0100 1324 0102 1320 0104 13F0 0106 13F4
0108 00F0 010A 0F00 010C 8000 010E F800
0110 0800 0204 00AA 0208 00AA 020C 00AA
0210 00AA 0214 00AA 0218 00AA 021E 00AA
0300 BEEF 0302 1357 0304 1357 0306 8003
0308 3400
08FF                                // invalid bit with opcode FF

/* tb.f */
+incdir+include
src/cpu_pkg.sv
src/register_file.sv
src/alu.sv
src/flag_unit.sv
src/shift_add_multiplier.sv
src/cpu_control.sv
src/cpu_top.sv
sim/cpu_sva.sv
sim/cpu_tb.sv

/* Makefile */
# Verilator flow for the core testbench, run from the project root
VERILATOR  ?= verilator
TOP        ?= cpu_tb
FILELIST   ?= tb.f
BUILD_DIR  ?= obj_dir
JOBS       ?= 4
LINT_FLAGS ?= --lint-only -Wall --timing
SIM_FLAGS  ?= --binary --timing --assert -Wno-fatal

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

# The run fails with the simulator's exit status
sim:
	$(VERILATOR) $(SIM_FLAGS) -j $(JOBS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

/* sim/cpu_tb.sv */
/*
 Testbench for cpu_top. Reads sim/cpu_testdata.hex relative to the project root.
 Memory and fetch delays are random with a fixed seed, so every run is the same.
*/
`include "cpu_config.svh"

module cpu_tb
   import cpu_pkg::*;
();

   localparam int DATA_WORDS = 2 ** (`CPU_ADDR_BITS - 1);

   logic    clk;
   logic    rst_n;
   addr_t   instr_ptr;
   logic    instr_valid;
   instr_t  cur_instr;
   logic    rd_en;
   logic    wr_en;
   addr_t   rd_addr;
   addr_t   wr_addr;
   word_t   wr_data;
   word_t   rd_data;
   logic    rd_done;
   logic    wr_done;
   status_t status;

   logic [31:0] testdata [0:511];
   instr_t      prog_mem [0:255];
   word_t       data_mem [0:DATA_WORDS-1];
   addr_t       exp_addr [$];
   word_t       exp_data [$];
   status_t     exp_status;
   addr_t       rd_addr_hold = '0;
   int          prog_len = 0;
   int          timeout_limit = 0;
   int          cycle_count = 0;
   int          stores_seen = 0;
   int          rd_wait = 0;
   int          wr_wait = 0;
   int          seed = 32'had23_f6e6;

   cpu_top cpu_top_inst (.*);

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   task automatic abort_run(input string reason);
      $display("%s", reason);
      $display("TB FAILED");
      $fatal(1, "simulation stopped on the first error");
   endtask

   task automatic load_testdata();
      int pos;
      int count;
      // Untouched words still differ by address
      for (int i = 0; i < DATA_WORDS; i++) begin
         data_mem[i] = word_t'({i[14:0], 1'b0}) ^ 16'h5A5A;
      end
      $readmemh("sim/cpu_testdata.hex", testdata);
      prog_len = int'(testdata[0]);
      if (prog_len <= 0 || prog_len > 256) begin
         abort_run("Test data file is missing or has a bad program length");
      end
      pos = 1;
      for (int i = 0; i < prog_len; i++) begin
         prog_mem[i] = testdata[pos + i];
      end
      pos = pos + prog_len;
      count = int'(testdata[pos]);
      for (int i = 0; i < count; i++) begin
         data_mem[i] = word_t'(testdata[pos + 1 + i]);
      end
      pos = pos + 1 + count;
      count = int'(testdata[pos]);
      for (int i = 0; i < count; i++) begin
         exp_addr.push_back(addr_t'(testdata[pos + 1 + 2 * i]));
         exp_data.push_back(word_t'(testdata[pos + 2 + 2 * i]));
      end
      exp_status = status_t'(testdata[pos + 1 + 2 * count]);
   endtask

   task automatic check_store(input addr_t addr, input word_t data);
      if (exp_addr.size() == 0) begin
         abort_run($sformatf("Unexpected extra store of %h to address %h", data, addr));
      end else if (addr !== exp_addr[0] || data !== exp_data[0]) begin
         abort_run($sformatf("MISMATCH at %0t: store %0d wrote %h to %h, expected %h to %h",
                             $time, stores_seen, data, addr, exp_data[0], exp_addr[0]));
      end else begin
         void'(exp_addr.pop_front());
         void'(exp_data.pop_front());
         stores_seen++;
      end
   endtask

   task automatic check_status(input status_t got);
      if (got !== exp_status) begin
         abort_run($sformatf("MISMATCH at %0t: status %h, expected %h",
                             $time, got, exp_status));
      end
   endtask

   // Fetch model drops instr_valid on about one cycle in four
   task automatic drive_fetch();
      int idx;
      idx = int'(instr_ptr[`CPU_ADDR_BITS-1:2]);
      instr_valid = (($random(seed) & 3) != 0);
      if (idx < prog_len) begin
         cur_instr = prog_mem[idx];
      end else begin
         cur_instr = 32'hFE00_0000;
      end
   endtask

   task automatic serve_read();
      if (rd_en) begin
         rd_addr_hold = rd_addr;
         rd_wait = $random(seed) & 3;
      end else if (rd_wait > 0) begin
         rd_wait = rd_wait - 1;
      end
      rd_done = (rd_wait == 0);
      if (rd_done) begin
         rd_data = data_mem[rd_addr_hold[`CPU_ADDR_BITS-1:1]];
      end
   endtask

   task automatic serve_write();
      if (wr_en) begin
         check_store(wr_addr, wr_data);
         data_mem[wr_addr[`CPU_ADDR_BITS-1:1]] = wr_data;
         wr_wait = $random(seed) & 3;
      end else if (wr_wait > 0) begin
         wr_wait = wr_wait - 1;
      end
      wr_done = (wr_wait == 0);
   endtask

   // All inputs change 1 unit after the rising edge
   always @(posedge clk) begin
      #1;
      drive_fetch();
      serve_read();
      serve_write();
   end

   always @(posedge clk) begin
      cycle_count = cycle_count + 1;
      if (timeout_limit > 0 && cycle_count >= timeout_limit) begin
         abort_run($sformatf("Timeout, the core did not finish within %0d cycles",
                             timeout_limit));
      end
   end

   initial begin
      rst_n       = 1'b0;
      instr_valid = 1'b0;
      cur_instr   = '0;
      rd_data     = '0;
      rd_done     = 1'b1;
      wr_done     = 1'b1;
      load_testdata();
      // Worst case per instruction is a fetch stall plus a multiply
      timeout_limit = prog_len * (4 + 18) + 100;
      repeat (4) @(posedge clk);
      #1 rst_n = 1'b1;
      do begin
         @(posedge clk);
         #2;
      end while (!status[`CPU_STATUS_INVALID]);
      check_status(status);
      // No store may follow the halt
      repeat (20) @(posedge clk);
      #2;
      check_status(status);
      if (exp_addr.size() != 0) begin
         abort_run($sformatf("Only %0d stores seen, %0d expected stores are missing",
                             stores_seen, exp_addr.size()));
      end else begin
         $display("TB PASSED");
         $finish;
      end
   end

endmodule

/* sim/cpu_sva.sv */
/*
 Protocol assertions for cpu_control, attached with bind.
*/
module cpu_sva
   import cpu_pkg::*;
(
   input logic        clk,
   input logic        rst_n,
   input logic        rd_en,
   input logic        wr_en,
   input logic        mul_start,
   input logic        mul_done,
   input ctrl_state_t state,
   input status_t     status
);

   // One memory request at a time
   rd_wr_exclusive: assert property (@(posedge clk) disable iff (!rst_n) !(rd_en && wr_en))
      else $error("rd_en and wr_en are high together");

   rd_en_pulse: assert property (@(posedge clk) disable iff (!rst_n) rd_en |=> !rd_en)
      else $error("rd_en is high for more than one cycle");

   wr_en_pulse: assert property (@(posedge clk) disable iff (!rst_n) wr_en |=> !wr_en)
      else $error("wr_en is high for more than one cycle");

   // Start only into an idle multiplier, which then turns busy
   mul_start_idle: assert property (@(posedge clk) disable iff (!rst_n)
      mul_start |-> mul_done ##1 !mul_done)
      else $error("mul_start while the multiplier is busy or not taken");

   // Frozen status once halted
   halt_status_stable: assert property (@(posedge clk) disable iff (!rst_n)
      (state == HALT) |=> $stable(status))
      else $error("status changed in HALT");

endmodule

bind cpu_control cpu_sva cpu_sva_inst (
   .clk       (clk),
   .rst_n     (rst_n),
   .rd_en     (rd_en),
   .wr_en     (wr_en),
   .mul_start (mul_start),
   .mul_done  (mul_done),
   .state     (state),
   .status    (status)
);

/* src/cpu_top.sv */
/*
 Core top level. Fetch starts at address zero right after reset.
*/
module cpu_top
   import cpu_pkg::*;
(
   input  logic    clk,
   input  logic    rst_n,
   output addr_t   instr_ptr,
   input  logic    instr_valid,
   input  instr_t  cur_instr,
   output logic    rd_en,
   output logic    wr_en,
   output addr_t   rd_addr,
   output addr_t   wr_addr,
   output word_t   wr_data,
   input  word_t   rd_data,
   input  logic    rd_done,
   input  logic    wr_done,
   output status_t status
);

   reg_idx_t                   rf_idx_a;
   reg_idx_t                   rf_idx_b;
   word_t                      rf_a;
   word_t                      rf_b;
   logic                       rf_we;
   reg_idx_t                   rf_widx;
   word_t                      rf_wdata;
   opcode_t                    alu_op;
   word_t                      alu_result;
   flags_t                     alu_flags;
   logic                       flag_update;
   logic                       take_branch;
   logic                       mul_start;
   word_t                      mul_a;
   word_t                      mul_b;
   logic                       mul_done;
   logic [2*$bits(word_t)-1:0] mul_product;

   cpu_control cpu_control_inst (
      .clk         (clk),
      .rst_n       (rst_n),
      .instr_ptr   (instr_ptr),
      .instr_valid (instr_valid),
      .cur_instr   (cur_instr),
      .rd_en       (rd_en),
      .rd_addr     (rd_addr),
      .rd_data     (rd_data),
      .rd_done     (rd_done),
      .wr_en       (wr_en),
      .wr_addr     (wr_addr),
      .wr_data     (wr_data),
      .wr_done     (wr_done),
      .rf_idx_a    (rf_idx_a),
      .rf_idx_b    (rf_idx_b),
      .rf_a        (rf_a),
      .rf_b        (rf_b),
      .rf_we       (rf_we),
      .rf_widx     (rf_widx),
      .rf_wdata    (rf_wdata),
      .alu_op      (alu_op),
      .alu_result  (alu_result),
      .alu_flags   (alu_flags),
      .flag_update (flag_update),
      .take_branch (take_branch),
      .mul_start   (mul_start),
      .mul_a       (mul_a),
      .mul_b       (mul_b),
      .mul_done    (mul_done),
      .mul_product (mul_product),
      .status      (status)
   );

   register_file register_file_inst (
      .clk       (clk),
      .rst_n     (rst_n),
      .rd_idx_a  (rf_idx_a),
      .rd_idx_b  (rf_idx_b),
      .rd_data_a (rf_a),
      .rd_data_b (rf_b),
      .wr_en     (rf_we),
      .wr_idx    (rf_widx),
      .wr_data   (rf_wdata)
   );

   // ALU operands come straight from the register read ports
   alu alu_inst (
      .op         (alu_op),
      .dest       (rf_a),
      .src        (rf_b),
      .result     (alu_result),
      .next_flags (alu_flags)
   );

   flag_unit flag_unit_inst (
      .clk         (clk),
      .rst_n       (rst_n),
      .update      (flag_update),
      .next_flags  (alu_flags),
      .op          (alu_op),
      .take_branch (take_branch)
   );

   shift_add_multiplier #(
      .BITS ($bits(word_t))
   ) shift_add_multiplier_inst (
      .clk     (clk),
      .rst_n   (rst_n),
      .start   (mul_start),
      .a       (mul_a),
      .b       (mul_b),
      .done    (mul_done),
      .product (mul_product)
   );

endmodule

/* src/cpu_control.sv */
/*
 Fetch/execute FSM with one instruction in flight. rd_en and wr_en are one-cycle
 pulses; memory must show the request on rd_done/wr_done by the next edge.
*/
`include "cpu_config.svh"

module cpu_control
   import cpu_pkg::*;
(
   input  logic                        clk,
   input  logic                        rst_n,
   output addr_t                       instr_ptr,
   input  logic                        instr_valid,
   input  instr_t                      cur_instr,
   output logic                        rd_en,
   output addr_t                       rd_addr,
   input  word_t                       rd_data,
   input  logic                        rd_done,
   output logic                        wr_en,
   output addr_t                       wr_addr,
   output word_t                       wr_data,
   input  logic                        wr_done,
   output reg_idx_t                    rf_idx_a,
   output reg_idx_t                    rf_idx_b,
   input  word_t                       rf_a,
   input  word_t                       rf_b,
   output logic                        rf_we,
   output reg_idx_t                    rf_widx,
   output word_t                       rf_wdata,
   output opcode_t                     alu_op,
   input  word_t                       alu_result,
   input  flags_t                      alu_flags,
   output logic                        flag_update,
   input  logic                        take_branch,
   output logic                        mul_start,
   output word_t                       mul_a,
   output word_t                       mul_b,
   input  logic                        mul_done,
   input  logic [2*$bits(word_t)-1:0]  mul_product,
   output status_t                     status
);

   ctrl_state_t state;
   opcode_t     op;
   reg_idx_t    reg1;
   reg_idx_t    reg2;
   word_t       arg_a;
   word_t       arg_b;
   reg_idx_t    load_reg;
   status_t     bad_status;
   logic        is_write;
   logic        is_load;
   logic        is_store;
   logic        is_mul;
   logic        is_jump;
   logic        is_bad;
   logic        stall;
   logic        exec_fire;

   assign op    = opcode_t'(cur_instr[31:24]);
   assign reg1  = cur_instr[19:16];
   assign reg2  = cur_instr[11:8];
   assign arg_a = cur_instr[23:8];
   assign arg_b = cur_instr[15:0];

   always_comb begin
      is_write = 1'b0;
      is_load  = 1'b0;
      is_store = 1'b0;
      is_mul   = 1'b0;
      is_jump  = 1'b0;
      is_bad   = 1'b0;
      case (op)
         OP_MOV, OP_MOVI, OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR,
         OP_SHL, OP_SHRA, OP_SHRL: is_write = 1'b1;
         // No register or memory effect
         OP_NOP, OP_CMP, OP_TST: is_bad = 1'b0;
         OP_LOAD, OP_LOADI: is_load = 1'b1;
         OP_STOR, OP_STORI: is_store = 1'b1;
         OP_MUL: is_mul = 1'b1;
         OP_JMP, OP_JMPI, OP_JEQ, OP_JNE, OP_JG, OP_JGE, OP_JA, OP_JAE,
         OP_JL, OP_JLE, OP_JB, OP_JBE, OP_JO, OP_JNO, OP_JS, OP_JNS: is_jump = 1'b1;
         default: is_bad = 1'b1;
      endcase
   end

   // Issue waits until the target unit reports done
   assign stall     = (is_load & ~rd_done) | (is_store & ~wr_done) | (is_mul & ~mul_done);
   assign exec_fire = (state == EXECUTING) & instr_valid & ~stall;

   assign rf_idx_a    = reg1;
   assign rf_idx_b    = reg2;
   assign alu_op      = op;
   assign flag_update = exec_fire;
   assign mul_start   = exec_fire & is_mul;
   assign mul_a       = rf_a;
   assign mul_b       = rf_b;

   always_comb begin
      bad_status = '0;
      bad_status[`CPU_STATUS_INVALID] = 1'b1;
      bad_status[7:0] = cur_instr[31:24];
   end

   // Register write source
   always_comb begin
      rf_we    = 1'b0;
      rf_widx  = reg1;
      rf_wdata = alu_result;
      case (state)
         EXECUTING: begin
            rf_we = instr_valid & is_write;
            if (op == OP_MOVI) begin
               rf_wdata = arg_b;
            end
         end
         RD_WAIT: begin
            rf_we    = rd_done;
            rf_widx  = load_reg;
            rf_wdata = rd_data;
         end
         MULTIPLY: begin
            rf_we    = mul_done;
            rf_widx  = load_reg;
            rf_wdata = mul_product[$bits(word_t)-1:0];
         end
         default: rf_we = 1'b0;
      endcase
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state     <= EXECUTING;
         instr_ptr <= '0;
         rd_en     <= 1'b0;
         wr_en     <= 1'b0;
         status    <= {EXECUTING, 8'h00};
      end else begin
         rd_en <= 1'b0;
         wr_en <= 1'b0;
         // Frozen once halted
         if (state != HALT) begin
            status <= {state, instr_ptr[7:0]};
         end
         case (state)
            EXECUTING: begin
               if (exec_fire) begin
                  if (is_jump && take_branch) begin
                     instr_ptr <= (op == OP_JMP) ? rf_a : arg_a;
                  end else begin
                     instr_ptr <= instr_ptr + addr_t'(`CPU_INSTR_BYTES);
                  end
                  if (is_load) begin
                     rd_en <= 1'b1;
                     state <= RD_WAIT;
                  end
                  if (is_store) begin
                     wr_en <= 1'b1;
                     state <= WR_WAIT;
                  end
                  if (is_mul) begin
                     state <= MULTIPLY;
                  end
                  if (is_bad) begin
                     state  <= HALT;
                     status <= bad_status;
                  end
               end
            end
            RD_WAIT: begin
               if (rd_done) begin
                  state <= EXECUTING;
               end
            end
            WR_WAIT: begin
               if (wr_done) begin
                  state <= EXECUTING;
               end
            end
            MULTIPLY: begin
               if (mul_done) begin
                  state <= EXECUTING;
               end
            end
            default: state <= HALT;
         endcase
      end
   end

   // Request payload, only meaningful with its enable
   always_ff @(posedge clk) begin
      if (exec_fire && (is_load || is_mul)) begin
         load_reg <= reg1;
      end
      if (exec_fire && is_load) begin
         rd_addr <= (op == OP_LOAD) ? rf_b : arg_b;
      end
      if (exec_fire && is_store) begin
         wr_addr <= (op == OP_STOR) ? rf_b : arg_b;
         wr_data <= rf_a;
      end
   end

endmodule

/* src/shift_add_multiplier.sv */
/*
 Unsigned shift-add multiplier, one partial product per cycle.
 done is high while idle and falls at the edge that samples start.
*/
module shift_add_multiplier
   import cpu_pkg::*;
#(
   parameter int BITS = $bits(word_t)
) (
   input  logic              clk,
   input  logic              rst_n,
   input  logic              start,
   input  logic [BITS-1:0]   a,
   input  logic [BITS-1:0]   b,
   output logic              done,
   output logic [2*BITS-1:0] product
);

   localparam int CW = $clog2(BITS + 1);

   logic              busy;
   logic [CW-1:0]     count;
   logic [2*BITS-1:0] mcand;
   logic [BITS-1:0]   mplier;
   logic [2*BITS-1:0] acc;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         busy  <= 1'b0;
         count <= '0;
      end else if (start) begin
         busy  <= 1'b1;
         count <= CW'(BITS);
      end else if (busy) begin
         count <= count - 1'b1;
         if (count == CW'(1)) begin
            busy <= 1'b0;
         end
      end
   end

   // Multiplicand moves left as the multiplier bits move right
   always_ff @(posedge clk) begin
      if (start) begin
         mcand  <= {{BITS{1'b0}}, a};
         mplier <= b;
         acc    <= '0;
      end else if (busy) begin
         if (mplier[0]) begin
            acc <= acc + mcand;
         end
         mcand  <= mcand << 1;
         mplier <= mplier >> 1;
      end
   end

   assign done    = ~busy;
   assign product = acc;

endmodule

/* src/flag_unit.sv */
/*
 Condition flags and jump decision. take_branch is 0 for every non-jump opcode.
*/
module flag_unit
   import cpu_pkg::*;
(
   input  logic    clk,
   input  logic    rst_n,
   input  logic    update,
   input  flags_t  next_flags,
   input  opcode_t op,
   output logic    take_branch
);

   flags_t flags;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         flags <= '0;
      end else if (update) begin
         flags <= next_flags;
      end
   end

   always_comb begin
      case (op)
         OP_JMP, OP_JMPI: take_branch = 1'b1;
         OP_JEQ: take_branch = flags.zero;
         OP_JNE: take_branch = !flags.zero;
         // Signed compares
         OP_JG:  take_branch = !flags.zero && (flags.sign == flags.overflow);
         OP_JGE: take_branch = (flags.sign == flags.overflow);
         OP_JL:  take_branch = (flags.sign != flags.overflow);
         OP_JLE: take_branch = (flags.sign != flags.overflow) || flags.zero;
         // Unsigned compares
         OP_JA:  take_branch = !flags.carry && !flags.zero;
         OP_JAE: take_branch = !flags.carry;
         OP_JB:  take_branch = flags.carry;
         OP_JBE: take_branch = flags.carry || flags.zero;
         OP_JO:  take_branch = flags.overflow;
         OP_JNO: take_branch = !flags.overflow;
         OP_JS:  take_branch = flags.sign;
         OP_JNS: take_branch = !flags.sign;
         default: take_branch = 1'b0;
      endcase
   end

endmodule

/* src/alu.sv */
/*
 Register ALU. next_flags is all zero for opcodes that do not set flags,
 so loading it on every retire also clears the flags.
*/
module alu
   import cpu_pkg::*;
(
   input  opcode_t op,
   input  word_t   dest,
   input  word_t   src,
   output word_t   result,
   output flags_t  next_flags
);

   localparam int W = $bits(word_t);

   // One bit wider than a word to keep the carry
   logic [W:0] sum;
   logic [W:0] diff;
   logic [W:0] wide;
   logic       sets_flags;

   assign sum  = {1'b0, dest} + {1'b0, src};
   assign diff = {1'b0, dest} - {1'b0, src};

   always_comb begin
      result = '0;
      wide   = '0;
      case (op)
         OP_MOV:  result = src;
         OP_ADD: begin
            wide   = sum;
            result = sum[W-1:0];
         end
         OP_SUB: begin
            wide   = diff;
            result = diff[W-1:0];
         end
         // Compare only updates the flags
         OP_CMP:  wide = diff;
         OP_TST:  wide = {1'b0, dest & src};
         OP_AND:  result = dest & src;
         OP_OR:   result = dest | src;
         OP_XOR:  result = dest ^ src;
         OP_SHL:  result = dest << src;
         OP_SHRA: result = word_t'($signed(dest) >>> src);
         OP_SHRL: result = dest >> src;
         default: result = '0;
      endcase
   end

   assign sets_flags = (op == OP_ADD) || (op == OP_SUB) || (op == OP_CMP) || (op == OP_TST);

   always_comb begin
      next_flags = '0;
      if (sets_flags) begin
         next_flags.carry = wide[W];
         next_flags.zero  = (wide[W-1:0] == '0);
         next_flags.sign  = wide[W-1];
      end
      // Same operand signs with a flipped result sign
      if (op == OP_ADD) begin
         next_flags.overflow = (dest[W-1] & src[W-1] & ~wide[W-1]) |
                               (~dest[W-1] & ~src[W-1] & wide[W-1]);
      end else if (op == OP_SUB || op == OP_CMP) begin
         next_flags.overflow = (dest[W-1] & ~src[W-1] & ~wide[W-1]) |
                               (~dest[W-1] & src[W-1] & wide[W-1]);
      end
   end

endmodule

/* src/register_file.sv */
/*
 General registers with combinational reads and one synchronous write port.
 A read of the register being written returns the old value.
*/
`include "cpu_config.svh"

module register_file
   import cpu_pkg::*;
(
   input  logic     clk,
   input  logic     rst_n,
   input  reg_idx_t rd_idx_a,
   input  reg_idx_t rd_idx_b,
   output word_t    rd_data_a,
   output word_t    rd_data_b,
   input  logic     wr_en,
   input  reg_idx_t wr_idx,
   input  word_t    wr_data
);

   word_t regs [`CPU_NUM_REGS];

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int i = 0; i < `CPU_NUM_REGS; i++) begin
            regs[i] <= '0;
         end
      end else if (wr_en) begin
         regs[wr_idx] <= wr_data;
      end
   end

   assign rd_data_a = regs[rd_idx_a];
   assign rd_data_b = regs[rd_idx_b];

endmodule

/* src/cpu_pkg.sv */
/*
 Shared types of the core. Opcode codes are fixed and are used by the test program.
*/
`include "cpu_config.svh"

package cpu_pkg;

   typedef logic [`CPU_WORD_BITS-1:0] word_t;
   typedef logic [`CPU_ADDR_BITS-1:0] addr_t;

   // Opcode 31..24, arg1 23..16, arg2 15..8, argA 23..8, argB 15..0
   typedef logic [`CPU_INSTR_BITS-1:0] instr_t;

   typedef logic [$clog2(`CPU_NUM_REGS)-1:0] reg_idx_t;

   typedef enum logic [7:0] {
      OP_NOP   = 8'h00,
      OP_LOAD  = 8'h04,
      OP_LOADI = 8'h05,
      OP_MOV   = 8'h06,
      OP_MOVI  = 8'h07,
      OP_ADD   = 8'h0A,
      OP_SUB   = 8'h0B,
      OP_MUL   = 8'h0C,
      OP_AND   = 8'h0E,
      OP_OR    = 8'h0F,
      OP_XOR   = 8'h10,
      OP_SHL   = 8'h11,
      OP_SHRA  = 8'h12,
      OP_SHRL  = 8'h13,
      OP_CMP   = 8'h14,
      OP_TST   = 8'h15,
      OP_STOR  = 8'h18,
      OP_STORI = 8'h19,
      OP_JMP   = 8'h40,
      OP_JMPI  = 8'h41,
      OP_JEQ   = 8'h42,
      OP_JNE   = 8'h43,
      OP_JG    = 8'h44,
      OP_JGE   = 8'h45,
      OP_JA    = 8'h46,
      OP_JAE   = 8'h47,
      OP_JL    = 8'h48,
      OP_JLE   = 8'h49,
      OP_JB    = 8'h4A,
      OP_JBE   = 8'h4B,
      OP_JO    = 8'h4C,
      OP_JNO   = 8'h4D,
      OP_JS    = 8'h4E,
      OP_JNS   = 8'h4F
   } opcode_t;

   typedef struct packed {
      logic overflow;
      logic carry;
      logic zero;
      logic sign;
   } flags_t;

   typedef logic [`CPU_STATUS_BITS-1:0] status_t;

   // Codes stay below 8 to keep the status invalid bit free
   typedef enum logic [3:0] {
      HALT      = 4'd1,
      EXECUTING = 4'd2,
      WR_WAIT   = 4'd3,
      RD_WAIT   = 4'd5,
      MULTIPLY  = 4'd7
   } ctrl_state_t;

endpackage

/* include/cpu_config.svh */
/*
 Core widths and status layout. Every ctrl_state_t code must stay below 8
 so that the invalid-opcode bit of the status never collides with a state.
*/
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// Datapath and address widths
`define CPU_WORD_BITS 16
`define CPU_ADDR_BITS 16
`define CPU_INSTR_BITS 32

// Register file size
`define CPU_NUM_REGS 16

// Byte steps for word and instruction addressing
`define CPU_WORD_BYTES 2
`define CPU_INSTR_BYTES 4

// Status word is {state, instr_ptr[7:0]} or {invalid, opcode} in HALT
`define CPU_STATUS_BITS 12
`define CPU_STATUS_INVALID 11

`endif
